// ==== src/mc_bridge_pkg.sv ====
package mc_bridge_pkg;

  ////////////////////////////////////////////////////////////
  // mesh and bridge geometry
  ////////////////////////////////////////////////////////////
  localparam int MAX_OUTSTANDING = 8;
  localparam int NUM_TILES_X     = 4;
  localparam int NUM_TILES_Y     = 4;
  localparam int BLOCK_WORDS     = 4;

  // cache banks sit on the top and bottom rows, one per column each
  localparam int NUM_BANKS       = 2 * NUM_TILES_X;

  // dram address fields
  localparam int WORD_OFS_W      = $clog2(BLOCK_WORDS);
  localparam int BANK_W          = $clog2(NUM_BANKS);
  localparam int INDEX_LSB       = 2 + WORD_OFS_W + BANK_W;
  localparam int INDEX_W         = 20;

  ////////////////////////////////////////////////////////////
  // widths that carry a meaning
  ////////////////////////////////////////////////////////////
  typedef logic [31:0] eva_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  mask_t;
  typedef logic [19:0] net_addr_t;
  typedef logic [3:0]  x_cord_t;
  typedef logic [3:0]  y_cord_t;
  typedef logic [$clog2(MAX_OUTSTANDING)-1:0]   trans_id_t;
  typedef logic [$clog2(MAX_OUTSTANDING+1)-1:0] slot_cnt_t;

  // access size from the processor command
  typedef enum logic [1:0] {
    SIZE_1 = 2'd0,
    SIZE_2 = 2'd1,
    SIZE_4 = 2'd2
  } msg_size_e;

  // packet operation on the mesh
  typedef enum logic [1:0] {
    OP_LOAD         = 2'd0,
    OP_STORE        = 2'd1,
    OP_STORE_MASKED = 2'd2
  } net_op_e;

  // free slot count reads back from here
  localparam eva_t STATUS_ADDR = 32'h0000_2000;

endpackage

// ==== src/mc_eva_xlate.sv ====
`timescale 1ns/1ps

module mc_eva_xlate
  import mc_bridge_pkg::*;
(
  input  eva_t      cmd_addr_i
  , input  logic      cmd_we_i
  , input  msg_size_e cmd_size_i
  , input  word_t     cmd_data_i

  , output x_cord_t   net_x_o
  , output y_cord_t   net_y_o
  , output net_addr_t net_addr_o
  , output net_op_e   net_op_o
  , output mask_t     net_mask_o
  , output word_t     net_data_o
);

  logic                  is_dram;
  logic [1:0]            byte_ofs;
  logic [WORD_OFS_W-1:0] dram_word_ofs;
  logic [BANK_W-1:0]     dram_bank;
  logic [INDEX_W-1:0]    dram_index;
  mask_t                 size_mask;
  mask_t                 lane_mask;

  assign is_dram       = cmd_addr_i[31];
  assign byte_ofs      = cmd_addr_i[1:0];
  assign dram_word_ofs = cmd_addr_i[2 +: WORD_OFS_W];
  assign dram_bank     = cmd_addr_i[2 + WORD_OFS_W +: BANK_W];
  assign dram_index    = cmd_addr_i[INDEX_LSB +: INDEX_W];

  ////////////////////////////////////////////////////////////
  // destination
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    if (is_dram)
    begin
      // top bank bit picks top or bottom row, rest picks the column
      net_y_o    = dram_bank[BANK_W-1] ? y_cord_t'(NUM_TILES_Y - 1) : '0;
      net_x_o    = x_cord_t'(dram_bank[BANK_W-2:0]) + x_cord_t'(1);
      net_addr_o = net_addr_t'({dram_index, dram_word_ofs});
    end
    else
    begin
      // tile-local: coordinates sit right in the address
      net_y_o    = cmd_addr_i[29:26];
      net_x_o    = cmd_addr_i[25:22];
      net_addr_o = cmd_addr_i[21:2];
    end
  end

  ////////////////////////////////////////////////////////////
  // byte lanes
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    case (cmd_size_i)
      SIZE_1:  size_mask = 4'h1;
      SIZE_2:  size_mask = 4'h3;
      default: size_mask = 4'hf;
    endcase
  end

  assign lane_mask  = size_mask << byte_ofs;
  assign net_mask_o = lane_mask;

  // loads carry no payload
  assign net_data_o = cmd_we_i ? (cmd_data_i << {byte_ofs, 3'b000}) : '0;

  always_comb
  begin
    if (!cmd_we_i)
    begin
      net_op_o = OP_LOAD;
    end
    else if (lane_mask == 4'hf)
    begin
      net_op_o = OP_STORE;
    end
    else
    begin
      net_op_o = OP_STORE_MASKED;
    end
  end

endmodule

// ==== src/mc_trans_reorder.sv ====
`timescale 1ns/1ps

module mc_trans_reorder
  import mc_bridge_pkg::*;
(
  input  logic        clk_i
  , input  logic        rst_i

  // allocation, one per issued network request
  , input  logic        alloc_i
  , input  eva_t        alloc_addr_i
  , input  logic        alloc_we_i
  , input  msg_size_e   alloc_size_i
  , output logic        alloc_free_o
  , output trans_id_t   alloc_id_o
  , output slot_cnt_t   free_slots_o

  // network response write, any order
  , input  logic        wr_valid_i
  , input  trans_id_t   wr_id_i
  , input  word_t       wr_data_i

  // oldest entry, in command order
  , input  logic        deq_i
  , output logic        head_valid_o
  , output eva_t        head_addr_o
  , output logic        head_we_o
  , output msg_size_e   head_size_o
  , output word_t       head_data_o
);

  trans_id_t alloc_ptr_r;
  trans_id_t deq_ptr_r;
  slot_cnt_t free_cnt_r;
  logic [MAX_OUTSTANDING-1:0] done_r;

  // per-id copy of the command and the returned word
  eva_t      addr_mem [MAX_OUTSTANDING];
  logic      we_mem   [MAX_OUTSTANDING];
  msg_size_e size_mem [MAX_OUTSTANDING];
  word_t     data_mem [MAX_OUTSTANDING];

  ////////////////////////////////////////////////////////////
  // pointers and free count
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      alloc_ptr_r <= '0;
      deq_ptr_r   <= '0;
      free_cnt_r  <= slot_cnt_t'(MAX_OUTSTANDING);
    end
    else
    begin
      if (alloc_i)
        alloc_ptr_r <= alloc_ptr_r + trans_id_t'(1);
      if (deq_i)
        deq_ptr_r <= deq_ptr_r + trans_id_t'(1);

      // both in one cycle leaves the count alone
      case ({alloc_i, deq_i})
        2'b10:   free_cnt_r <= free_cnt_r - slot_cnt_t'(1);
        2'b01:   free_cnt_r <= free_cnt_r + slot_cnt_t'(1);
        default: free_cnt_r <= free_cnt_r;
      endcase
    end
  end

  // done flags, set by the network and cleared on the way out
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      done_r <= '0;
    end
    else
    begin
      if (wr_valid_i)
        done_r[wr_id_i] <= 1'b1;
      if (deq_i)
        done_r[deq_ptr_r] <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // command and data store
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (alloc_i)
    begin
      addr_mem[alloc_ptr_r] <= alloc_addr_i;
      we_mem[alloc_ptr_r]   <= alloc_we_i;
      size_mem[alloc_ptr_r] <= alloc_size_i;
    end
  end

  // store acks come back with junk data, keep zero instead
  always_ff @(posedge clk_i)
  begin
    if (wr_valid_i)
      data_mem[wr_id_i] <= we_mem[wr_id_i] ? '0 : wr_data_i;
  end

  assign alloc_free_o = (free_cnt_r != '0);
  assign alloc_id_o   = alloc_ptr_r;
  assign free_slots_o = free_cnt_r;

  // head only shows once its own response is in
  assign head_valid_o = done_r[deq_ptr_r];
  assign head_addr_o  = addr_mem[deq_ptr_r];
  assign head_we_o    = we_mem[deq_ptr_r];
  assign head_size_o  = size_mem[deq_ptr_r];
  assign head_data_o  = data_mem[deq_ptr_r];

endmodule

// ==== src/mc_cce_bridge.sv ====
`timescale 1ns/1ps

module mc_cce_bridge
  import mc_bridge_pkg::*;
(
  input  logic        clk_i
  , input  logic        rst_i

  // processor commands
  , input  logic        cmd_valid_i
  , output logic        cmd_ready_o
  , input  eva_t        cmd_addr_i
  , input  logic        cmd_we_i
  , input  msg_size_e   cmd_size_i
  , input  word_t       cmd_data_i

  // processor responses
  , output logic        resp_valid_o
  , input  logic        resp_ready_i
  , output eva_t        resp_addr_o
  , output logic        resp_we_o
  , output msg_size_e   resp_size_o
  , output word_t       resp_data_o

  // mesh requests
  , output logic        net_req_valid_o
  , input  logic        net_req_ready_i
  , output x_cord_t     net_req_x_o
  , output y_cord_t     net_req_y_o
  , output net_addr_t   net_req_addr_o
  , output net_op_e     net_req_op_o
  , output mask_t       net_req_mask_o
  , output word_t       net_req_data_o
  , output trans_id_t   net_req_id_o

  // mesh responses, never stalled
  , input  logic        net_resp_valid_i
  , input  trans_id_t   net_resp_id_i
  , input  word_t       net_resp_data_i
);

  logic      status_sel;
  logic      alloc;
  logic      alloc_free;
  slot_cnt_t free_slots;
  logic      deq;
  logic      head_valid;
  eva_t      head_addr;
  logic      head_we;
  msg_size_e head_size;
  word_t     head_data;

  mc_eva_xlate u_xlate (
    .cmd_addr_i  (cmd_addr_i)
    , .cmd_we_i    (cmd_we_i)
    , .cmd_size_i  (cmd_size_i)
    , .cmd_data_i  (cmd_data_i)
    , .net_x_o     (net_req_x_o)
    , .net_y_o     (net_req_y_o)
    , .net_addr_o  (net_req_addr_o)
    , .net_op_o    (net_req_op_o)
    , .net_mask_o  (net_req_mask_o)
    , .net_data_o  (net_req_data_o)
  );

  mc_trans_reorder u_reorder (
    .clk_i          (clk_i)
    , .rst_i          (rst_i)
    , .alloc_i        (alloc)
    , .alloc_addr_i   (cmd_addr_i)
    , .alloc_we_i     (cmd_we_i)
    , .alloc_size_i   (cmd_size_i)
    , .alloc_free_o   (alloc_free)
    , .alloc_id_o     (net_req_id_o)
    , .free_slots_o   (free_slots)
    , .wr_valid_i     (net_resp_valid_i)
    , .wr_id_i        (net_resp_id_i)
    , .wr_data_i      (net_resp_data_i)
    , .deq_i          (deq)
    , .head_valid_o   (head_valid)
    , .head_addr_o    (head_addr)
    , .head_we_o      (head_we)
    , .head_size_o    (head_size)
    , .head_data_o    (head_data)
  );

  ////////////////////////////////////////////////////////////
  // command dispatch
  ////////////////////////////////////////////////////////////
  assign status_sel = cmd_valid_i & ~cmd_we_i & (cmd_addr_i == STATUS_ADDR);

  assign net_req_valid_o = cmd_valid_i & ~status_sel & alloc_free;
  assign alloc           = net_req_valid_o & net_req_ready_i;

  // status read answers on the spot and wins the response port
  always_comb
  begin
    if (status_sel)
    begin
      cmd_ready_o  = resp_ready_i;
      resp_valid_o = 1'b1;
      resp_addr_o  = cmd_addr_i;
      resp_we_o    = 1'b0;
      resp_size_o  = cmd_size_i;
      resp_data_o  = word_t'(free_slots);
      deq          = 1'b0;
    end
    else
    begin
      cmd_ready_o  = alloc_free & net_req_ready_i;
      resp_valid_o = head_valid;
      resp_addr_o  = head_addr;
      resp_we_o    = head_we;
      resp_size_o  = head_size;
      resp_data_o  = head_data;
      deq          = head_valid & resp_ready_i;
    end
  end

endmodule

// ==== bench/tb_net_model.sv ====
`timescale 1ns/1ps

module tb_net_model
  import mc_bridge_pkg::*;
(
  input  logic        clk_i
  , input  logic        rst_i
  , input  logic        req_valid_i
  , output logic        req_ready_o
  , input  x_cord_t     req_x_i
  , input  y_cord_t     req_y_i
  , input  net_addr_t   req_addr_i
  , input  net_op_e     req_op_i
  , input  mask_t       req_mask_i
  , input  word_t       req_data_i
  , input  trans_id_t   req_id_i
  , output logic        resp_valid_o
  , output trans_id_t   resp_id_o
  , output word_t       resp_data_o
);

  integer      seed;
  word_t       mem [logic [27:0]];
  logic        pend      [MAX_OUTSTANDING];
  int          wait_cnt  [MAX_OUTSTANDING];
  word_t       pend_data [MAX_OUTSTANDING];
  logic [27:0] key;
  word_t       old_word;
  word_t       lanes;
  logic        sent;

  // byte mask widened to a bit mask
  function automatic word_t lane_bits(input mask_t m);
    word_t w;
    w = '0;
    for (int i = 0; i < 4; i++)
      if (m[i])
        w[8*i +: 8] = 8'hff;
    return w;
  endfunction

  initial
  begin
    seed = 32'h3a0b004f;
    for (int i = 0; i < MAX_OUTSTANDING; i++)
    begin
      pend[i]      = 1'b0;
      wait_cnt[i]  = 0;
      pend_data[i] = '0;
    end
    req_ready_o  = 1'b0;
    resp_valid_o = 1'b0;
    resp_id_o    = '0;
    resp_data_o  = '0;
    forever
    begin
      @(posedge clk_i);
      // accept a request, stores land in memory right away
      if (!rst_i && req_valid_i && req_ready_o)
      begin
        key      = {req_x_i, req_y_i, req_addr_i};
        old_word = mem.exists(key) ? mem[key] : '0;
        lanes    = lane_bits(req_mask_i);
        if (req_op_i != OP_LOAD)
        begin
          mem[key] = (old_word & ~lanes) | (req_data_i & lanes);
          // junk payload, the bridge must drop it
          pend_data[req_id_i] = ~old_word;
        end
        else
        begin
          pend_data[req_id_i] = old_word & lanes;
        end
        pend[req_id_i]     = 1'b1;
        wait_cnt[req_id_i] = $random(seed) & 7;
      end

      @(negedge clk_i);
      // one reply per cycle, lowest ready id first
      resp_valid_o = 1'b0;
      sent         = 1'b0;
      for (int i = 0; i < MAX_OUTSTANDING; i++)
      begin
        if (pend[i] && wait_cnt[i] == 0 && !sent)
        begin
          resp_valid_o = 1'b1;
          resp_id_o    = trans_id_t'(i);
          resp_data_o  = pend_data[i];
          pend[i]      = 1'b0;
          sent         = 1'b1;
        end
        else if (pend[i] && wait_cnt[i] > 0)
        begin
          wait_cnt[i] = wait_cnt[i] - 1;
        end
      end
      req_ready_o = (($random(seed) & 3) != 0);
    end
  end

endmodule

// ==== bench/tb_mc_cce_bridge.sv ====
`timescale 1ns/1ps

module tb_mc_cce_bridge
  import mc_bridge_pkg::*;
;

  localparam int NROWS = 30;
  localparam int LIMIT = 64 * NROWS + 200;

  logic      clk_i = 1'b0;
  logic      rst_i;
  logic      cmd_valid_i, cmd_ready_o, cmd_we_i;
  eva_t      cmd_addr_i;
  msg_size_e cmd_size_i;
  word_t     cmd_data_i;
  logic      resp_valid_o, resp_ready_i, resp_we_o;
  eva_t      resp_addr_o;
  msg_size_e resp_size_o;
  word_t     resp_data_o;
  logic      net_req_valid_o, net_req_ready_i;
  x_cord_t   net_req_x_o;
  y_cord_t   net_req_y_o;
  net_addr_t net_req_addr_o;
  net_op_e   net_req_op_o;
  mask_t     net_req_mask_o;
  word_t     net_req_data_o;
  trans_id_t net_req_id_o;
  logic      net_resp_valid_i;
  trans_id_t net_resp_id_i;
  word_t     net_resp_data_i;

  // stimulus table with expected values
  // mode 1 holds responses back and mode 2 expects a full bridge before release
  string     t_name  [NROWS];
  eva_t      t_addr  [NROWS];
  logic      t_we    [NROWS];
  msg_size_e t_size  [NROWS];
  word_t     t_data  [NROWS];
  x_cord_t   t_x     [NROWS];
  y_cord_t   t_y     [NROWS];
  net_addr_t t_naddr [NROWS];
  mask_t     t_mask  [NROWS];
  word_t     t_rdata [NROWS];
  logic [1:0] t_mode [NROWS];
  logic      req_bad [NROWS];

  int nrows = 0;
  int cur_row = 0;
  int req_ptr = 0;
  int req_seen = 0;
  int resp_ptr = 0;
  int req_errs = 0;
  int resp_errs = 0;
  int issue_errs = 0;
  int done_cnt = 0;
  int pass_cnt = 0;
  int cycles = 0;

  always #4 clk_i = ~clk_i;

  mc_cce_bridge dut (.*);

  tb_net_model u_net (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_valid_i  (net_req_valid_o),
    .req_ready_o  (net_req_ready_i),
    .req_x_i      (net_req_x_o),
    .req_y_i      (net_req_y_o),
    .req_addr_i   (net_req_addr_o),
    .req_op_i     (net_req_op_o),
    .req_mask_i   (net_req_mask_o),
    .req_data_i   (net_req_data_o),
    .req_id_i     (net_req_id_o),
    .resp_valid_o (net_resp_valid_i),
    .resp_id_o    (net_resp_id_i),
    .resp_data_o  (net_resp_data_i)
  );

  task automatic add_row(input string n, input eva_t a, input logic we, input msg_size_e s,
                         input word_t d, input x_cord_t x, input y_cord_t y,
                         input net_addr_t na, input mask_t m, input word_t rd,
                         input logic [1:0] mode);
    t_name[nrows]  = n;
    t_addr[nrows]  = a;
    t_we[nrows]    = we;
    t_size[nrows]  = s;
    t_data[nrows]  = d;
    t_x[nrows]     = x;
    t_y[nrows]     = y;
    t_naddr[nrows] = na;
    t_mask[nrows]  = m;
    t_rdata[nrows] = rd;
    t_mode[nrows]  = mode;
    nrows = nrows + 1;
  endtask

  function automatic logic is_status(input int r);
    return !t_we[r] && t_addr[r] == STATUS_ADDR;
  endfunction

  // next row that goes out on the mesh
  function automatic int next_net_row(input int from);
    int r;
    r = from;
    while (r < NROWS && is_status(r))
      r = r + 1;
    return r;
  endfunction

  function automatic net_op_e exp_op(input int r);
    if (!t_we[r])
      return OP_LOAD;
    else if (t_mask[r] == 4'hf)
      return OP_STORE;
    return OP_STORE_MASKED;
  endfunction

  // byte mask widened to a bit mask
  function automatic word_t mask_bits(input mask_t m);
    word_t w;
    w = '0;
    for (int i = 0; i < 4; i++)
      if (m[i])
        w[8*i +: 8] = 8'hff;
    return w;
  endfunction

  // store bytes fill the masked lanes from the lowest one up
  function automatic word_t placed_data(input int r);
    word_t w;
    int    k;
    w = '0;
    k = 0;
    for (int i = 0; i < 4; i++)
    begin
      if (t_mask[r][i])
      begin
        w[8*i +: 8] = t_data[r][8*k +: 8];
        k = k + 1;
      end
    end
    return w;
  endfunction

  function automatic int differs(input int r, input string what,
                                 input logic [31:0] e, input logic [31:0] a);
    if (e !== a)
    begin
      $display("Fail %s %s expected %h actual %h", t_name[r], what, e, a);
      return 1;
    end
    return 0;
  endfunction

  ////////////////////////////////////////////////////////////
  // monitors
  ////////////////////////////////////////////////////////////
  always @(posedge clk_i)
  begin
    int r;
    int bad;
    if (!rst_i && net_req_valid_o && net_req_ready_i)
    begin
      r = next_net_row(req_ptr);
      if (r >= NROWS)
      begin
        $display("mesh request seen with no command left in the table");
        req_errs = req_errs + 1;
      end
      else
      begin
        bad = 0;
        bad += differs(r, "x", 32'(t_x[r]), 32'(net_req_x_o));
        bad += differs(r, "y", 32'(t_y[r]), 32'(net_req_y_o));
        bad += differs(r, "net_addr", 32'(t_naddr[r]), 32'(net_req_addr_o));
        bad += differs(r, "mask", 32'(t_mask[r]), 32'(net_req_mask_o));
        bad += differs(r, "op", 32'(exp_op(r)), 32'(net_req_op_o));
        // ids go out in turn around the slots
        bad += differs(r, "id", 32'(req_seen % MAX_OUTSTANDING), 32'(net_req_id_o));
        if (t_we[r])
          bad += differs(r, "data", placed_data(r), net_req_data_o & mask_bits(t_mask[r]));
        else
          bad += differs(r, "data", 32'h0, net_req_data_o);
        req_bad[r] = (bad != 0);
        req_errs = req_errs + bad;
        req_ptr = r + 1;
      end
      req_seen = req_seen + 1;
    end
  end

  always @(posedge clk_i)
  begin
    int r;
    int bad;
    if (!rst_i && resp_valid_o && resp_ready_i)
    begin
      if (cmd_valid_i && !cmd_we_i && cmd_addr_i == STATUS_ADDR)
      begin
        r = cur_row;
      end
      else
      begin
        r = next_net_row(resp_ptr);
        resp_ptr = r + 1;
      end
      if (r >= NROWS)
      begin
        $display("response seen with no command left in the table");
        resp_errs = resp_errs + 1;
      end
      else
      begin
        bad = 0;
        bad += differs(r, "resp_addr", t_addr[r], resp_addr_o);
        bad += differs(r, "resp_we", 32'(t_we[r]), 32'(resp_we_o));
        bad += differs(r, "resp_size", 32'(t_size[r]), 32'(resp_size_o));
        bad += differs(r, "resp_data", t_rdata[r], resp_data_o);
        resp_errs = resp_errs + bad;
        if (bad == 0 && !(req_bad[r] === 1'b1))
        begin
          $display("%s ok", t_name[r]);
          pass_cnt = pass_cnt + 1;
        end
        else
        begin
          $display("%s failed", t_name[r]);
        end
        done_cnt = done_cnt + 1;
      end
    end
  end

  always @(posedge clk_i)
  begin
    cycles = cycles + 1;
    if (cycles >= LIMIT)
    begin
      $display("timeout after %0d cycles, responses never arrived", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////
  task automatic issue_row(input int r);
    if (t_mode[r] == 2'd1 && r > 0 && t_mode[r-1] == 2'd0)
      wait (done_cnt == r);
    if (done_cnt == r)
      @(negedge clk_i);
    cur_row      = r;
    cmd_valid_i  = 1'b1;
    cmd_addr_i   = t_addr[r];
    cmd_we_i     = t_we[r];
    cmd_size_i   = t_size[r];
    cmd_data_i   = t_data[r];
    resp_ready_i = (t_mode[r] == 2'd0) || is_status(r);
    if (t_mode[r] == 2'd2)
    begin
      // all slots taken so the command must wait
      repeat (3)
      begin
        @(posedge clk_i);
        if (cmd_ready_o || net_req_valid_o)
        begin
          $display("%s accepted while 8 commands were outstanding", t_name[r]);
          issue_errs = issue_errs + 1;
        end
      end
      @(negedge clk_i);
      resp_ready_i = 1'b1;
    end
    do
      @(posedge clk_i);
    while (!cmd_ready_o);
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  initial
  begin
    rst_i        = 1'b1;
    cmd_valid_i  = 1'b0;
    cmd_addr_i   = '0;
    cmd_we_i     = 1'b0;
    cmd_size_i   = SIZE_4;
    cmd_data_i   = '0;
    resp_ready_i = 1'b1;

    add_row("status_reset", STATUS_ADDR, 1'b0, SIZE_4, 32'h0, 4'd0, 4'd0, 20'h0, 4'h0, 32'd8, 2'd0);
    add_row("tile_store", 32'h0840_0040, 1'b1, SIZE_4, 32'hdead_beef,
            4'd1, 4'd2, 20'h00010, 4'hf, 32'h0, 2'd0);
    add_row("tile_load", 32'h0840_0040, 1'b0, SIZE_4, 32'h0,
            4'd1, 4'd2, 20'h00010, 4'hf, 32'hdead_beef, 2'd0);
    // dram hash, index 5 and word offset 1 in every bank
    for (int b = 0; b < NUM_BANKS; b++)
      add_row($sformatf("dram_bank%0d", b), 32'h8000_0284 + eva_t'(b * 16), 1'b0, SIZE_4,
              32'h0, x_cord_t'(b % 4 + 1), (b >= 4) ? 4'd3 : 4'd0, 20'h00015, 4'hf,
              32'h0, 2'd0);
    add_row("lane_word", 32'h0840_0080, 1'b1, SIZE_4, 32'h1122_3344,
            4'd1, 4'd2, 20'h00020, 4'hf, 32'h0, 2'd0);
    add_row("lane_byte0", 32'h0840_0080, 1'b1, SIZE_1, 32'h99, 4'd1, 4'd2, 20'h00020, 4'h1,
            32'h0, 2'd0);
    add_row("lane_byte1", 32'h0840_0081, 1'b1, SIZE_1, 32'haa, 4'd1, 4'd2, 20'h00020, 4'h2,
            32'h0, 2'd0);
    add_row("lane_byte2", 32'h0840_0082, 1'b1, SIZE_1, 32'hbb, 4'd1, 4'd2, 20'h00020, 4'h4,
            32'h0, 2'd0);
    add_row("lane_byte3", 32'h0840_0083, 1'b1, SIZE_1, 32'hcc, 4'd1, 4'd2, 20'h00020, 4'h8,
            32'h0, 2'd0);
    add_row("lane_half0", 32'h0840_0080, 1'b1, SIZE_2, 32'h1234, 4'd1, 4'd2, 20'h00020, 4'h3,
            32'h0, 2'd0);
    add_row("lane_half2", 32'h0840_0082, 1'b1, SIZE_2, 32'h5678, 4'd1, 4'd2, 20'h00020, 4'hc,
            32'h0, 2'd0);
    add_row("lane_load", 32'h0840_0080, 1'b0, SIZE_4, 32'h0, 4'd1, 4'd2, 20'h00020, 4'hf,
            32'h5678_1234, 2'd0);
    for (int i = 0; i < 8; i++)
      add_row($sformatf("held_load%0d", i), (i % 2 == 0) ? 32'h0840_0040 : 32'h0840_0080,
              1'b0, SIZE_4, 32'h0, 4'd1, 4'd2, (i % 2 == 0) ? 20'h00010 : 20'h00020, 4'hf,
              (i % 2 == 0) ? 32'hdead_beef : 32'h5678_1234, 2'd1);
    add_row("status_full", STATUS_ADDR, 1'b0, SIZE_4, 32'h0, 4'd0, 4'd0, 20'h0, 4'h0, 32'd0, 2'd1);
    add_row("full_store", 32'h0840_0100, 1'b1, SIZE_4, 32'hcafe_f00d,
            4'd1, 4'd2, 20'h00040, 4'hf, 32'h0, 2'd2);
    add_row("full_load", 32'h0840_0100, 1'b0, SIZE_4, 32'h0,
            4'd1, 4'd2, 20'h00040, 4'hf, 32'hcafe_f00d, 2'd0);

    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    if (resp_valid_o || net_req_valid_o)
    begin
      $display("valid outputs high after reset with no command");
      issue_errs = issue_errs + 1;
    end

    for (int r = 0; r < NROWS; r++)
      issue_row(r);
    resp_ready_i = 1'b1;
    wait (done_cnt == NROWS);
    repeat (4) @(posedge clk_i);

    $display("rows %0d passed %0d failed %0d check errors %0d", NROWS, pass_cnt,
             NROWS - pass_cnt, req_errs + resp_errs + issue_errs);
    if (req_errs + resp_errs + issue_errs == 0 && pass_cnt == NROWS)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== mc_cce_bridge.f ====
src/mc_bridge_pkg.sv
src/mc_eva_xlate.sv
src/mc_trans_reorder.sv
src/mc_cce_bridge.sv
bench/tb_net_model.sv
bench/tb_mc_cce_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the bridge testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f mc_cce_bridge.f \
  --top-module tb_mc_cce_bridge \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
